/* logic/block_fill_dma.sv */
/*
 * Block fill DMA controller
 * writes pattern + k to count words from a start address, then interrupts
 */
`timescale 1ns/100ps

module block_fill_dma
#(
   parameter pdp_bus_pkg::word_t dma_vector = 16'o220
)
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   dma_reg_sel,
   input  logic [1:0]             dma_reg_offset,
   input  logic                   reg_wr,
   input  logic                   reg_byte_op,
   input  logic                   reg_byte_hi,
   input  pdp_bus_pkg::word_t     reg_wdata,
   output pdp_bus_pkg::word_t     dma_reg_rdata,
   output logic                   dma_req,
   output pdp_bus_pkg::dma_addr_t dma_addr,
   output pdp_bus_pkg::word_t     dma_wdata,
   output logic                   dma_wr,
   input  logic                   dma_ack,
   output logic                   bus_int,
   output pdp_bus_pkg::word_t     bus_int_vector,
   input  logic                   interrupt_ack
);

   import pdp_bus_pkg::*;

   typedef enum logic [1:0] {idle, filling, finish} dma_state_t;

   dma_state_t state;
   logic       ie;
   logic       done;
   logic       reg_write;
   logic       csr_wr;
   logic       go;
   word_t      addr_reg;
   word_t      count_reg;
   word_t      pattern_reg;
   dma_addr_t  cur_addr;
   word_t      cur_count;
   word_t      cur_data;

   // byte writes replace only their own lane
   function automatic word_t merge(input word_t old_val, input word_t new_val,
                                   input logic byte_op, input logic byte_hi);
      if (!byte_op)
         return new_val;
      return byte_hi ? {new_val[15:8], old_val[7:0]} : {old_val[15:8], new_val[7:0]};
   endfunction

   assign reg_write = dma_reg_sel && reg_wr;
   // csr bits all live in the low byte
   assign csr_wr = reg_write && dma_reg_offset == 2'd0 && !(reg_byte_op && reg_byte_hi);
   assign go     = csr_wr && reg_wdata[csr_go] && state == idle;

   always_ff @(posedge clk)
   begin
      if (reg_write)
      begin
         case (dma_reg_offset)
            2'd1: addr_reg <= merge(addr_reg, reg_wdata, reg_byte_op, reg_byte_hi);
            2'd2: count_reg <= merge(count_reg, reg_wdata, reg_byte_op, reg_byte_hi);
            2'd3: pattern_reg <= merge(pattern_reg, reg_wdata, reg_byte_op, reg_byte_hi);
            default: ;
         endcase
      end
      if (go)
      begin
         cur_addr  <= {2'b0, addr_reg};
         cur_count <= count_reg;
         cur_data  <= pattern_reg;
      end
      else if (dma_wr)
      begin
         cur_addr  <= cur_addr + 18'd2;
         cur_count <= cur_count - 16'd1;
         cur_data  <= cur_data + 16'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state   <= idle;
         ie      <= 1'b0;
         done    <= 1'b1;
         bus_int <= 1'b0;
      end
      else
      begin
         if (csr_wr)
            ie <= reg_wdata[csr_ie];
         if (interrupt_ack)
            bus_int <= 1'b0;
         case (state)
            idle:
               if (go)
               begin
                  // an empty block completes at once
                  done  <= count_reg == '0;
                  state <= (count_reg == '0) ? idle : filling;
               end
            filling:
               if (dma_wr && cur_count == 16'd1)
               begin
                  done  <= 1'b1;
                  state <= finish;
                  if (ie)
                     bus_int <= 1'b1;
               end
            default:
               state <= idle;
         endcase
      end
   end

   always_comb
   begin
      dma_reg_rdata = '0;
      case (dma_reg_offset)
         2'd0:
         begin
            dma_reg_rdata[csr_done] = done;
            dma_reg_rdata[csr_ie]   = ie;
         end
         2'd1: dma_reg_rdata = addr_reg;
         2'd2: dma_reg_rdata = count_reg;
         default: dma_reg_rdata = pattern_reg;
      endcase
   end

   assign dma_req        = state == filling;
   assign dma_wr         = dma_req && dma_ack;
   assign dma_addr       = cur_addr;
   assign dma_wdata      = cur_data;
   assign bus_int_vector = dma_vector;

   // the switch only grants a live request
   assert property (@(posedge clk) disable iff (reset) dma_ack |-> dma_wr);
   // bursts are capped at four writes
   assert property (@(posedge clk) disable iff (reset) dma_wr [*4] |=> !dma_wr);

endmodule

/* logic/bus_switch.sv */
/*
 * Bus switch
 * latches CPU requests, decodes memory or I/O page, shares memory with DMA
 */
`timescale 1ns/100ps

module bus_switch
#(
   parameter int mem_words = 4096
)
(
   input  logic                   clk,
   input  logic                   reset,
   // CPU port
   input  pdp_bus_pkg::paddr_t    bus_addr,
   input  pdp_bus_pkg::word_t     bus_data_in,
   input  logic                   bus_rd,
   input  logic                   bus_wr,
   input  logic                   bus_byte_op,
   input  logic                   bus_arbitrate,
   output pdp_bus_pkg::word_t     bus_data_out,
   output logic                   bus_ack,
   output logic                   bus_error,
   // memory port
   output pdp_bus_pkg::paddr_t    ram_addr,
   output pdp_bus_pkg::word_t     ram_wdata,
   output logic                   ram_rd,
   output logic                   ram_wr,
   output logic                   ram_byte_op,
   input  pdp_bus_pkg::word_t     ram_rdata,
   // I/O page port
   output pdp_bus_pkg::paddr_t    io_addr,
   output pdp_bus_pkg::word_t     io_wdata,
   output logic                   io_rd,
   output logic                   io_wr,
   output logic                   io_byte_op,
   input  pdp_bus_pkg::word_t     io_rdata,
   input  logic                   io_no_decode,
   // DMA port
   input  logic                   dma_req,
   input  pdp_bus_pkg::dma_addr_t dma_addr,
   input  pdp_bus_pkg::word_t     dma_wdata,
   input  logic                   dma_wr,
   output logic                   dma_ack
);

   import pdp_bus_pkg::*;

   grant_state_t grant_state;
   logic         cpu_req;
   logic         grant_cpu;
   logic         grant_dma;
   paddr_t       hold_addr;
   word_t        hold_data;
   logic         hold_rd;
   logic         hold_wr;
   logic         hold_byte_op;
   logic         iopage_access;
   logic         ram_present;

   assign cpu_req = bus_rd || bus_wr;

   grant_arbiter arbiter
   (
      .clk           (clk),
      .reset         (reset),
      .cpu_req       (cpu_req),
      .dma_req       (dma_req),
      .bus_arbitrate (bus_arbitrate),
      .grant_state   (grant_state)
   );

   assign grant_cpu = grant_state == cpu_grant;
   assign grant_dma = grant_state inside {dma_grant_0, dma_grant_1, dma_grant_2, dma_grant_3};

   // request captured in every idle cycle, held through the grant
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         hold_rd <= 1'b0;
         hold_wr <= 1'b0;
      end
      else if (grant_state == idle)
      begin
         hold_rd <= bus_rd;
         hold_wr <= bus_wr;
      end
   end

   always_ff @(posedge clk)
   begin
      if (grant_state == idle)
      begin
         hold_addr    <= bus_addr;
         hold_data    <= bus_data_in;
         hold_byte_op <= bus_byte_op;
      end
   end

   assign iopage_access = hold_addr >= iopage_base;
   // word index against the fitted memory size
   assign ram_present = 32'(hold_addr[21:1]) < 32'(mem_words);

   // memory port, DMA owns it during a burst
   assign ram_addr    = grant_dma ? {4'b0, dma_addr} : hold_addr;
   assign ram_wdata   = grant_dma ? dma_wdata : hold_data;
   assign ram_byte_op = grant_dma ? 1'b0 : hold_byte_op;
   assign ram_rd      = grant_cpu && hold_rd && !iopage_access && ram_present;
   assign ram_wr      = grant_dma ? dma_wr
                                  : grant_cpu && hold_wr && !iopage_access && ram_present;

   assign io_addr    = hold_addr;
   assign io_wdata   = hold_data;
   assign io_byte_op = hold_byte_op;
   assign io_rd      = grant_cpu && hold_rd && iopage_access;
   assign io_wr      = grant_cpu && hold_wr && iopage_access;

   assign bus_data_out = iopage_access ? io_rdata : ram_rdata;
   assign bus_ack      = !cpu_req || grant_cpu;
   assign bus_error    = grant_cpu && (iopage_access ? io_no_decode : !ram_present);
   assign dma_ack      = grant_dma && dma_req;

   // memory and I/O page writes come from different grant states
   assert property (@(posedge clk) disable iff (reset) !(ram_wr && io_wr));

endmodule

/* logic/grant_arbiter.sv */
/*
 * Memory grant arbiter
 * one-cycle CPU grants, or DMA bursts of up to four writes
 */
`timescale 1ns/100ps

module grant_arbiter
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      cpu_req,
   input  logic                      dma_req,
   input  logic                      bus_arbitrate,
   output pdp_bus_pkg::grant_state_t grant_state
);

   import pdp_bus_pkg::*;

   grant_state_t state_next;

   always_comb
   begin
      state_next = idle;
      case (grant_state)
         idle:
         begin
            // DMA only when the CPU lets go of the bus
            if (dma_req && bus_arbitrate)
               state_next = dma_grant_0;
            else if (cpu_req)
               state_next = cpu_grant;
         end
         dma_grant_0:
            if (dma_req)
               state_next = dma_grant_1;
         dma_grant_1:
            if (dma_req)
               state_next = dma_grant_2;
         dma_grant_2:
            if (dma_req)
               state_next = dma_grant_3;
         // cpu_grant and the last burst cycle
         default:
            state_next = idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         grant_state <= idle;
      else
         grant_state <= state_next;
   end

   // a CPU cycle hands the bus back before any burst
   assert property (@(posedge clk) disable iff (reset)
      grant_state == cpu_grant |=>
         !(grant_state inside {dma_grant_0, dma_grant_1, dma_grant_2, dma_grant_3}));

endmodule

/* logic/iopage_decode.sv */
/*
 * I/O page decoder
 * selects the switch register or the DMA registers, flags undecoded addresses
 */
`timescale 1ns/100ps

module iopage_decode
(
   input  logic                clk,
   input  logic                reset,
   input  pdp_bus_pkg::paddr_t io_addr,
   input  pdp_bus_pkg::word_t  io_wdata,
   input  logic                io_rd,
   input  logic                io_wr,
   input  logic                io_byte_op,
   output pdp_bus_pkg::word_t  io_rdata,
   output logic                io_no_decode,
   input  pdp_bus_pkg::word_t  switches,
   // DMA register port
   output logic                dma_reg_sel,
   output logic [1:0]          dma_reg_offset,
   output logic                dma_reg_wr,
   output logic                dma_reg_byte_op,
   output logic                dma_reg_byte_hi,
   output pdp_bus_pkg::word_t  dma_reg_wdata,
   input  pdp_bus_pkg::word_t  dma_reg_rdata
);

   import pdp_bus_pkg::*;

   logic io_access;
   logic sw_hit;
   logic dma_hit;

   assign io_access = io_rd || io_wr;
   // odd byte addresses hit the same word
   assign sw_hit  = io_addr[21:1] == switch_reg_addr[21:1];
   assign dma_hit = io_addr[21:3] == dma_reg_base[21:3];

   assign dma_reg_sel     = io_access && dma_hit;
   assign dma_reg_offset  = io_addr[2:1];
   assign dma_reg_wr      = io_wr;
   assign dma_reg_byte_op = io_byte_op;
   assign dma_reg_byte_hi = io_addr[0];
   assign dma_reg_wdata   = io_wdata;

   always_comb
   begin
      io_rdata = '0;
      if (sw_hit)
         io_rdata = switches;
      else if (dma_hit)
         io_rdata = dma_reg_rdata;
   end

   // switch register writes fall through silently
   assign io_no_decode = io_access && !sw_hit && !dma_hit;

   // each I/O access is a single grant cycle
   assert property (@(posedge clk) disable iff (reset)
      io_access |=> !io_access);

endmodule

/* logic/main_memory.sv */
/*
 * Main memory
 * 16-bit words with byte lane writes and combinational read
 */
`timescale 1ns/100ps

module main_memory
#(
   parameter int mem_words = 4096
)
(
   input  logic                clk,
   input  pdp_bus_pkg::paddr_t ram_addr,
   input  pdp_bus_pkg::word_t  ram_wdata,
   input  logic                ram_rd,
   input  logic                ram_wr,
   input  logic                ram_byte_op,
   output pdp_bus_pkg::word_t  ram_rdata
);

   import pdp_bus_pkg::*;

   localparam int aw = $clog2(mem_words);

   word_t          mem [mem_words];
   logic [aw-1:0]  word_idx;

   // addresses wrap within the fitted size
   assign word_idx  = ram_addr[aw:1];
   assign ram_rdata = ram_rd ? mem[word_idx] : '0;

   always_ff @(posedge clk)
   begin
      if (ram_wr && (!ram_byte_op || !ram_addr[0]))
         mem[word_idx][7:0] <= ram_wdata[7:0];
      if (ram_wr && (!ram_byte_op || ram_addr[0]))
         mem[word_idx][15:8] <= ram_wdata[15:8];
   end

endmodule

/* logic/pdp_bus_pkg.sv */
/*
 * PDP-11 style memory bus definitions
 * address and data types, arbiter states and the I/O page map
 */
package pdp_bus_pkg;

   // 22-bit physical byte address
   typedef logic [21:0] paddr_t;
   typedef logic [15:0] word_t;
   // DMA devices only reach the low 256 KB
   typedef logic [17:0] dma_addr_t;

   typedef enum logic [2:0]
   {
      idle        = 3'd0,
      cpu_grant   = 3'd1,
      dma_grant_0 = 3'd4,
      dma_grant_1 = 3'd5,
      dma_grant_2 = 3'd6,
      dma_grant_3 = 3'd7
   } grant_state_t;

   // top 8 KB of the physical space
   localparam paddr_t iopage_base     = 22'o17760000;
   localparam paddr_t switch_reg_addr = 22'o17777570;
   // csr, address, count and pattern at word offsets 0 to 3
   localparam paddr_t dma_reg_base    = 22'o17777400;

   // DMA csr bits
   localparam int csr_go   = 0;
   localparam int csr_ie   = 6;
   localparam int csr_done = 7;

endpackage

/* logic/pdp_bus_top.sv */
/*
 * PDP-11 style memory bus top level
 * bus switch, I/O page, block fill DMA and main memory
 */
`timescale 1ns/100ps

module pdp_bus_top
#(
   parameter int                 mem_words  = 4096,
   parameter pdp_bus_pkg::word_t dma_vector = 16'o220
)
(
   input  logic                clk,
   input  logic                reset,
   input  pdp_bus_pkg::paddr_t bus_addr,
   input  pdp_bus_pkg::word_t  bus_data_in,
   input  logic                bus_rd,
   input  logic                bus_wr,
   input  logic                bus_byte_op,
   input  logic                bus_arbitrate,
   output pdp_bus_pkg::word_t  bus_data_out,
   output logic                bus_ack,
   output logic                bus_error,
   output logic                bus_int,
   output pdp_bus_pkg::word_t  bus_int_vector,
   input  logic                interrupt_ack,
   input  pdp_bus_pkg::word_t  switches
);

   import pdp_bus_pkg::*;

   paddr_t    ram_addr;
   word_t     ram_wdata;
   word_t     ram_rdata;
   logic      ram_rd;
   logic      ram_wr;
   logic      ram_byte_op;
   paddr_t    io_addr;
   word_t     io_wdata;
   word_t     io_rdata;
   logic      io_rd;
   logic      io_wr;
   logic      io_byte_op;
   logic      io_no_decode;
   logic      dma_reg_sel;
   logic [1:0] dma_reg_offset;
   logic      dma_reg_wr;
   logic      dma_reg_byte_op;
   logic      dma_reg_byte_hi;
   word_t     dma_reg_wdata;
   word_t     dma_reg_rdata;
   logic      dma_req;
   dma_addr_t dma_addr;
   word_t     dma_wdata;
   logic      dma_wr;
   logic      dma_ack;

   bus_switch #(.mem_words(mem_words)) switch_u
   (
      .clk           (clk),
      .reset         (reset),
      .bus_addr      (bus_addr),
      .bus_data_in   (bus_data_in),
      .bus_rd        (bus_rd),
      .bus_wr        (bus_wr),
      .bus_byte_op   (bus_byte_op),
      .bus_arbitrate (bus_arbitrate),
      .bus_data_out  (bus_data_out),
      .bus_ack       (bus_ack),
      .bus_error     (bus_error),
      .ram_addr      (ram_addr),
      .ram_wdata     (ram_wdata),
      .ram_rd        (ram_rd),
      .ram_wr        (ram_wr),
      .ram_byte_op   (ram_byte_op),
      .ram_rdata     (ram_rdata),
      .io_addr       (io_addr),
      .io_wdata      (io_wdata),
      .io_rd         (io_rd),
      .io_wr         (io_wr),
      .io_byte_op    (io_byte_op),
      .io_rdata      (io_rdata),
      .io_no_decode  (io_no_decode),
      .dma_req       (dma_req),
      .dma_addr      (dma_addr),
      .dma_wdata     (dma_wdata),
      .dma_wr        (dma_wr),
      .dma_ack       (dma_ack)
   );

   iopage_decode iopage_u
   (
      .clk             (clk),
      .reset           (reset),
      .io_addr         (io_addr),
      .io_wdata        (io_wdata),
      .io_rd           (io_rd),
      .io_wr           (io_wr),
      .io_byte_op      (io_byte_op),
      .io_rdata        (io_rdata),
      .io_no_decode    (io_no_decode),
      .switches        (switches),
      .dma_reg_sel     (dma_reg_sel),
      .dma_reg_offset  (dma_reg_offset),
      .dma_reg_wr      (dma_reg_wr),
      .dma_reg_byte_op (dma_reg_byte_op),
      .dma_reg_byte_hi (dma_reg_byte_hi),
      .dma_reg_wdata   (dma_reg_wdata),
      .dma_reg_rdata   (dma_reg_rdata)
   );

   block_fill_dma #(.dma_vector(dma_vector)) dma_u
   (
      .clk            (clk),
      .reset          (reset),
      .dma_reg_sel    (dma_reg_sel),
      .dma_reg_offset (dma_reg_offset),
      .reg_wr         (dma_reg_wr),
      .reg_byte_op    (dma_reg_byte_op),
      .reg_byte_hi    (dma_reg_byte_hi),
      .reg_wdata      (dma_reg_wdata),
      .dma_reg_rdata  (dma_reg_rdata),
      .dma_req        (dma_req),
      .dma_addr       (dma_addr),
      .dma_wdata      (dma_wdata),
      .dma_wr         (dma_wr),
      .dma_ack        (dma_ack),
      .bus_int        (bus_int),
      .bus_int_vector (bus_int_vector),
      .interrupt_ack  (interrupt_ack)
   );

   main_memory #(.mem_words(mem_words)) memory_u
   (
      .clk         (clk),
      .ram_addr    (ram_addr),
      .ram_wdata   (ram_wdata),
      .ram_rd      (ram_rd),
      .ram_wr      (ram_wr),
      .ram_byte_op (ram_byte_op),
      .ram_rdata   (ram_rdata)
   );

endmodule

/* run_sim.sh */
#!/bin/sh
# build the PDP-11 bus testbench with Verilator, run it and scan the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_pdp_bus -f src.f > build.log 2>&1 \
   || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_pdp_bus > sim.log 2>&1
cat sim.log
grep -q "Test failures found" sim.log && exit 1
grep -q "All tests passed!" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

/* src.f */
logic/pdp_bus_pkg.sv
logic/grant_arbiter.sv
logic/bus_switch.sv
logic/iopage_decode.sv
logic/block_fill_dma.sv
logic/main_memory.sv
logic/pdp_bus_top.sv
testbench/tb_pdp_bus.sv

/* testbench/tb_pdp_bus.sv */
/*
 * Testbench for the PDP-11 style memory bus
 * directed tests against a reference memory model
 */
`timescale 1ns/100ps

module tb_pdp_bus;

   import pdp_bus_pkg::*;

   localparam int    mem_words  = 1024;
   localparam word_t dma_vector = 16'o254;
   // about four times the full test run
   localparam int    timeout_cycles = 2000;

   logic   clk;
   logic   reset;
   paddr_t bus_addr;
   word_t  bus_data_in;
   logic   bus_rd;
   logic   bus_wr;
   logic   bus_byte_op;
   logic   bus_arbitrate;
   word_t  bus_data_out;
   logic   bus_ack;
   logic   bus_error;
   logic   bus_int;
   word_t  bus_int_vector;
   logic   interrupt_ack;
   word_t  switches;

   word_t       ref_mem [mem_words];
   logic [31:0] rng_state = 32'he17a_905f;
   int          cycle_count = 0;
   int          wait_cycles;

   pdp_bus_top #(.mem_words(mem_words), .dma_vector(dma_vector)) DUT
   (
      .clk            (clk),
      .reset          (reset),
      .bus_addr       (bus_addr),
      .bus_data_in    (bus_data_in),
      .bus_rd         (bus_rd),
      .bus_wr         (bus_wr),
      .bus_byte_op    (bus_byte_op),
      .bus_arbitrate  (bus_arbitrate),
      .bus_data_out   (bus_data_out),
      .bus_ack        (bus_ack),
      .bus_error      (bus_error),
      .bus_int        (bus_int),
      .bus_int_vector (bus_int_vector),
      .interrupt_ack  (interrupt_ack),
      .switches       (switches)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= timeout_cycles)
      begin
         $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
         abort_run();
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic abort_run();
      $display("Test failures found");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic check_word(input string name, input word_t expected, input word_t actual);
      if (actual !== expected)
      begin
         $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
         abort_run();
      end
   endtask

   // one CPU access, request held until bus_ack
   task automatic bus_cycle(input paddr_t addr, input word_t wdata, input logic wr,
                            input logic byte_op, output word_t rdata, output logic err);
      @(negedge clk);
      bus_addr    = addr;
      bus_data_in = wdata;
      bus_rd      = !wr;
      bus_wr      = wr;
      bus_byte_op = byte_op;
      wait_cycles = 1;
      @(negedge clk);
      while (!bus_ack)
      begin
         wait_cycles = wait_cycles + 1;
         @(negedge clk);
      end
      rdata  = bus_data_out;
      err    = bus_error;
      bus_rd = 1'b0;
      bus_wr = 1'b0;
   endtask

   task automatic cpu_write(input string name, input paddr_t addr, input word_t data,
                            input logic byte_op, input logic exp_err);
      word_t rdata;
      logic  err;
      int    widx;
      widx = int'(addr[21:1]);
      bus_cycle(addr, data, 1'b1, byte_op, rdata, err);
      check_flag(name, exp_err, err);
      // only present memory words keep what is written
      if (addr < iopage_base && widx < mem_words)
      begin
         if (!byte_op)
            ref_mem[widx] = data;
         else if (addr[0])
            ref_mem[widx][15:8] = data[15:8];
         else
            ref_mem[widx][7:0] = data[7:0];
      end
   endtask

   task automatic cpu_read_check(input string name, input paddr_t addr,
                                 input word_t expected, input logic exp_err);
      word_t rdata;
      logic  err;
      bus_cycle(addr, '0, 1'b0, 1'b0, rdata, err);
      check_flag(name, exp_err, err);
      if (!exp_err)
         check_word(name, expected, rdata);
   endtask

   task automatic mem_read_check(input string name, input paddr_t addr);
      cpu_read_check(name, addr, ref_mem[int'(addr[21:1])], 1'b0);
   endtask

   task automatic start_fill(input int first_word, input int count, input word_t pattern,
                             input logic ie);
      word_t csr_val;
      csr_val         = '0;
      csr_val[csr_ie] = ie;
      csr_val[csr_go] = 1'b1;
      cpu_write("fill start reg", dma_reg_base + 22'd2, 16'(2 * first_word), 1'b0, 1'b0);
      cpu_write("fill count reg", dma_reg_base + 22'd4, 16'(count), 1'b0, 1'b0);
      cpu_write("fill pattern reg", dma_reg_base + 22'd6, pattern, 1'b0, 1'b0);
      cpu_write("fill go", dma_reg_base, csr_val, 1'b0, 1'b0);
   endtask

   task automatic wait_dma_done(input string name);
      word_t csr;
      logic  err;
      csr = '0;
      while (!csr[csr_done])
      begin
         bus_cycle(dma_reg_base, '0, 1'b0, 1'b0, csr, err);
         check_flag(name, 1'b0, err);
      end
   endtask

   // word k holds pattern + k, the word after the block is read as well
   task automatic check_fill(input string name, input int first_word, input int count,
                             input word_t pattern);
      int k;
      for (k = 0; k < count; k++)
         ref_mem[first_word + k] = pattern + word_t'(k);
      for (k = 0; k <= count; k++)
         mem_read_check(name, 22'(2 * (first_word + k)));
   endtask

   task automatic word_readback();
      paddr_t addrs [12];
      int     i;
      for (i = 0; i < 12; i++)
      begin
         rng_state = xorshift32(rng_state);
         addrs[i]  = 22'(2 * (int'(rng_state[15:0]) % mem_words));
         rng_state = xorshift32(rng_state);
         cpu_write("word write", addrs[i], rng_state[31:16], 1'b0, 1'b0);
      end
      for (i = 0; i < 12; i++)
         mem_read_check("word read", addrs[i]);
   endtask

   task automatic byte_lane_merge();
      paddr_t addr;
      int     i;
      for (i = 0; i < 3; i++)
      begin
         rng_state = xorshift32(rng_state);
         addr      = 22'(2 * (int'(rng_state[15:0]) % mem_words));
         cpu_write("byte base", addr, rng_state[31:16], 1'b0, 1'b0);
         rng_state = xorshift32(rng_state);
         cpu_write("byte low", addr, rng_state[15:0], 1'b1, 1'b0);
         mem_read_check("byte low read", addr);
         cpu_write("byte high", addr + 22'd1, rng_state[31:16], 1'b1, 1'b0);
         mem_read_check("byte high read", addr);
      end
   endtask

   task automatic absent_memory();
      paddr_t wrapped;
      paddr_t absent;
      wrapped = 22'd200;
      absent  = wrapped + 22'(2 * mem_words);
      cpu_write("absent setup", wrapped, 16'h5a5a, 1'b0, 1'b0);
      cpu_read_check("absent read", absent, '0, 1'b1);
      cpu_write("absent write", absent, 16'hdead, 1'b0, 1'b1);
      mem_read_check("absent wrap read", wrapped);
      cpu_read_check("absent far read", 22'o1000000, '0, 1'b1);
   endtask

   task automatic iopage_devices();
      cpu_read_check("switch read", switch_reg_addr, switches, 1'b0);
      cpu_write("switch write", switch_reg_addr, 16'hffff, 1'b0, 1'b0);
      @(negedge clk);
      switches = 16'o070707;
      cpu_read_check("switch reread", switch_reg_addr, 16'o070707, 1'b0);
      cpu_read_check("undecoded read", 22'o17770000, '0, 1'b1);
      cpu_write("undecoded write", 22'o17776000, 16'h1111, 1'b0, 1'b1);
      // only done is set out of reset
      cpu_read_check("csr after reset", dma_reg_base, 16'o200, 1'b0);
      cpu_write("start reg write", dma_reg_base + 22'd2, 16'o4000, 1'b0, 1'b0);
      cpu_read_check("start reg read", dma_reg_base + 22'd2, 16'o4000, 1'b0);
      cpu_write("count reg write", dma_reg_base + 22'd4, 16'd9, 1'b0, 1'b0);
      cpu_read_check("count reg read", dma_reg_base + 22'd4, 16'd9, 1'b0);
      cpu_write("pattern reg write", dma_reg_base + 22'd6, 16'h1234, 1'b0, 1'b0);
      cpu_write("pattern high byte", dma_reg_base + 22'd7, 16'hab00, 1'b1, 1'b0);
      cpu_read_check("pattern high read", dma_reg_base + 22'd6, 16'hab34, 1'b0);
      cpu_write("pattern low byte", dma_reg_base + 22'd6, 16'h00cd, 1'b1, 1'b0);
      cpu_read_check("pattern low read", dma_reg_base + 22'd6, 16'habcd, 1'b0);
   endtask

   task automatic dma_block_fill();
      word_t pattern;
      rng_state = xorshift32(rng_state);
      pattern   = rng_state[15:0];
      cpu_write("fill guard", 22'(2 * (512 + 20)), 16'hc0de, 1'b0, 1'b0);
      @(negedge clk);
      bus_arbitrate = 1'b1;
      start_fill(512, 20, pattern, 1'b1);
      wait_dma_done("fill poll");
      cpu_read_check("fill csr", dma_reg_base, 16'o300, 1'b0);
      @(negedge clk);
      bus_arbitrate = 1'b0;
      check_flag("fill interrupt", 1'b1, bus_int);
      check_word("fill vector", dma_vector, bus_int_vector);
      interrupt_ack = 1'b1;
      @(negedge clk);
      interrupt_ack = 1'b0;
      @(negedge clk);
      check_flag("interrupt cleared", 1'b0, bus_int);
      check_fill("fill data", 512, 20, pattern);
   endtask

   task automatic cpu_during_dma();
      word_t  pattern;
      paddr_t addr;
      int     longest;
      int     i;
      longest   = 0;
      rng_state = xorshift32(rng_state);
      pattern   = rng_state[15:0];
      cpu_write("overlap guard", 22'(2 * (768 + 24)), 16'hbeef, 1'b0, 1'b0);
      @(negedge clk);
      bus_arbitrate = 1'b1;
      start_fill(768, 24, pattern, 1'b0);
      // low words only, away from the block being filled
      for (i = 0; i < 8; i++)
      begin
         rng_state = xorshift32(rng_state);
         addr      = 22'(2 * int'(rng_state[5:0]));
         cpu_write("overlap write", addr, rng_state[31:16], 1'b0, 1'b0);
         longest = (wait_cycles > longest) ? wait_cycles : longest;
         mem_read_check("overlap read", addr);
         longest = (wait_cycles > longest) ? wait_cycles : longest;
      end
      check_flag("cpu held off by dma", 1'b1, longest > 1);
      wait_dma_done("overlap poll");
      cpu_read_check("overlap csr", dma_reg_base, 16'o200, 1'b0);
      check_flag("no interrupt", 1'b0, bus_int);
      @(negedge clk);
      bus_arbitrate = 1'b0;
      check_fill("overlap fill data", 768, 24, pattern);
   endtask

   initial
   begin
      reset         = 1'b1;
      bus_addr      = '0;
      bus_data_in   = '0;
      bus_rd        = 1'b0;
      bus_wr        = 1'b0;
      bus_byte_op   = 1'b0;
      bus_arbitrate = 1'b0;
      interrupt_ack = 1'b0;
      switches      = 16'o123456;
      repeat (5) @(negedge clk);
      reset = 1'b0;
      check_flag("idle ack", 1'b1, bus_ack);
      check_flag("reset interrupt", 1'b0, bus_int);

      word_readback();
      byte_lane_merge();
      absent_memory();
      iopage_devices();
      dma_block_fill();
      cpu_during_dma();

      $display("All tests passed!");
      $finish;
   end

endmodule
